// ==== rtl/fpu_ss_pkg.sv ====
/*
 * fpu subsystem package
 * widths, instruction encodings, CSR addresses and the structs shared
 * between the request buffer, decoder, controller and execution stage
 */
`default_nettype none

package fpu_ss_pkg;

  localparam int xlen         = 32;
  localparam int flen         = 32;
  localparam int reg_addr_w   = 5;
  localparam int buffer_depth = 2;

  // major opcodes
  localparam logic [6:0] opcode_op_fp  = 7'b1010011;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // funct7 values with the single-precision format bits included
  localparam logic [6:0] funct7_sgnj       = 7'b0010000;
  localparam logic [6:0] funct7_minmax     = 7'b0010100;
  localparam logic [6:0] funct7_cmp        = 7'b1010000;
  localparam logic [6:0] funct7_class_mvxw = 7'b1110000;
  localparam logic [6:0] funct7_mvwx       = 7'b1111000;

  localparam logic [11:0] csr_fflags = 12'h001;
  localparam logic [11:0] csr_frm    = 12'h002;
  localparam logic [11:0] csr_fcsr   = 12'h003;

  localparam logic [flen-1:0] qnan_canon = 32'h7fc00000;
  // invalid operation bit in fflags
  localparam int flag_nv = 4;

  typedef enum logic [3:0] {
    op_sgnj, op_sgnjn, op_sgnjx,
    op_min, op_max,
    op_eq, op_lt, op_le,
    op_class, op_mv_xw, op_mv_wx,
    op_csr, op_illegal
  } fp_op_e;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] hart_id;
  } offload_req_t;

  typedef struct packed {
    logic [xlen-1:0]       data;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       hart_id;
    logic                  error;
  } offload_rsp_t;

  typedef struct packed {
    fp_op_e                op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_is_fp;
    logic                  uses_fpr_rs1;
    logic                  uses_fpr_rs2;
    logic                  is_csr;
  } decoded_t;

  typedef struct packed {
    decoded_t        dec;
    logic [flen-1:0] operand_a;
    logic [flen-1:0] operand_b;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] hart_id;
  } issue_t;

endpackage

`default_nettype wire

// ==== rtl/fpu_ss_buffer.sv ====
/*
 * request buffer
 * circular valid/ready FIFO for offloaded instructions; an empty buffer
 * passes a push straight through to the pop side in the same cycle
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      push_valid_i,
  output logic                      push_ready_o,
  input  fpu_ss_pkg::offload_req_t  push_data_i,
  output logic                      pop_valid_o,
  input  logic                      pop_ready_i,
  output fpu_ss_pkg::offload_req_t  pop_data_o
);

  typedef logic [$clog2(fpu_ss_pkg::buffer_depth)-1:0]   ptr_t;
  typedef logic [$clog2(fpu_ss_pkg::buffer_depth+1)-1:0] cnt_t;

  fpu_ss_pkg::offload_req_t mem_q [fpu_ss_pkg::buffer_depth];
  ptr_t rptr_q;
  ptr_t wptr_q;
  cnt_t count_q;
  logic empty;
  logic push_fire;
  logic store;
  logic pop_mem;

  assign empty        = (count_q == '0);
  // ready drops only once every slot holds an entry
  assign push_ready_o = (count_q != cnt_t'(fpu_ss_pkg::buffer_depth));
  assign pop_valid_o  = !empty || push_valid_i;
  assign pop_data_o   = empty ? push_data_i : mem_q[rptr_q];

  assign push_fire = push_valid_i && push_ready_o;
  // bypassed pushes never touch the storage
  assign store     = push_fire && !(empty && pop_ready_i);
  assign pop_mem   = pop_ready_i && !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q  <= '0;
      wptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (store) begin
        wptr_q <= (wptr_q == ptr_t'(fpu_ss_pkg::buffer_depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop_mem) begin
        rptr_q <= (rptr_q == ptr_t'(fpu_ss_pkg::buffer_depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(store) - cnt_t'(pop_mem);
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_decoder.sv ====
/*
 * instruction decoder
 * maps an offloaded instruction word to the operation, register fields
 * and routing flags; anything outside the supported subset is illegal
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_decoder (
  input  logic [fpu_ss_pkg::xlen-1:0] instr_i,
  output fpu_ss_pkg::decoded_t        dec_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       rs2_zero;

  assign opcode   = instr_i[6:0];
  assign funct7   = instr_i[31:25];
  assign funct3   = instr_i[14:12];
  assign rs2_zero = (instr_i[24:20] == 5'd0);

  always_comb begin
    dec_o     = '0;
    dec_o.rs1 = instr_i[19:15];
    dec_o.rs2 = instr_i[24:20];
    dec_o.rd  = instr_i[11:7];
    dec_o.op  = fpu_ss_pkg::op_illegal;

    if (opcode == fpu_ss_pkg::opcode_op_fp) begin
      // funct7 carries the fmt field, so double or half formats fall out here
      case (funct7)
        fpu_ss_pkg::funct7_sgnj: begin
          case (funct3)
            3'b000: dec_o.op = fpu_ss_pkg::op_sgnj;
            3'b001: dec_o.op = fpu_ss_pkg::op_sgnjn;
            3'b010: dec_o.op = fpu_ss_pkg::op_sgnjx;
            default: dec_o.op = fpu_ss_pkg::op_illegal;
          endcase
        end
        fpu_ss_pkg::funct7_minmax: begin
          case (funct3)
            3'b000: dec_o.op = fpu_ss_pkg::op_min;
            3'b001: dec_o.op = fpu_ss_pkg::op_max;
            default: dec_o.op = fpu_ss_pkg::op_illegal;
          endcase
        end
        fpu_ss_pkg::funct7_cmp: begin
          case (funct3)
            3'b010: dec_o.op = fpu_ss_pkg::op_eq;
            3'b001: dec_o.op = fpu_ss_pkg::op_lt;
            3'b000: dec_o.op = fpu_ss_pkg::op_le;
            default: dec_o.op = fpu_ss_pkg::op_illegal;
          endcase
        end
        fpu_ss_pkg::funct7_class_mvxw: begin
          if (rs2_zero && funct3 == 3'b000) begin
            dec_o.op = fpu_ss_pkg::op_mv_xw;
          end else if (rs2_zero && funct3 == 3'b001) begin
            dec_o.op = fpu_ss_pkg::op_class;
          end
        end
        fpu_ss_pkg::funct7_mvwx: begin
          if (rs2_zero && funct3 == 3'b000) begin
            dec_o.op = fpu_ss_pkg::op_mv_wx;
          end
        end
        default: dec_o.op = fpu_ss_pkg::op_illegal;
      endcase
    end else if (opcode == fpu_ss_pkg::opcode_system) begin
      // funct3 000 is ecall/ebreak space and 100 is reserved
      if (funct3[1:0] != 2'b00) begin
        dec_o.op = fpu_ss_pkg::op_csr;
      end
    end

    case (dec_o.op)
      fpu_ss_pkg::op_sgnj, fpu_ss_pkg::op_sgnjn, fpu_ss_pkg::op_sgnjx,
      fpu_ss_pkg::op_min, fpu_ss_pkg::op_max: begin
        dec_o.rd_is_fp     = 1'b1;
        dec_o.uses_fpr_rs1 = 1'b1;
        dec_o.uses_fpr_rs2 = 1'b1;
      end
      fpu_ss_pkg::op_eq, fpu_ss_pkg::op_lt, fpu_ss_pkg::op_le: begin
        dec_o.uses_fpr_rs1 = 1'b1;
        dec_o.uses_fpr_rs2 = 1'b1;
      end
      fpu_ss_pkg::op_class, fpu_ss_pkg::op_mv_xw: dec_o.uses_fpr_rs1 = 1'b1;
      fpu_ss_pkg::op_mv_wx: dec_o.rd_is_fp = 1'b1;
      fpu_ss_pkg::op_csr: dec_o.is_csr = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_csr.sv ====
/*
 * floating-point CSRs
 * holds fflags and frm, performs the CSR read-modify-write at issue and
 * accumulates the invalid flag of retiring instructions
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_csr (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [fpu_ss_pkg::xlen-1:0] instr_i,
  input  logic [fpu_ss_pkg::xlen-1:0] rs1_val_i,
  input  logic                        csr_en_i,
  input  logic [4:0]                  flags_set_i,
  input  logic                        flags_set_en_i,
  output logic [fpu_ss_pkg::xlen-1:0] rdata_o
);

  logic [4:0]                  fflags_q;
  logic [4:0]                  fflags_d;
  logic [2:0]                  frm_q;
  logic [2:0]                  frm_d;
  logic [11:0]                 addr;
  logic [2:0]                  funct3;
  logic [fpu_ss_pkg::xlen-1:0] operand;
  logic [fpu_ss_pkg::xlen-1:0] old_val;
  logic [fpu_ss_pkg::xlen-1:0] new_val;

  assign addr   = instr_i[31:20];
  assign funct3 = instr_i[14:12];
  // immediate forms use the rs1 field as a zero-extended uimm
  assign operand = funct3[2] ? {{(fpu_ss_pkg::xlen-5){1'b0}}, instr_i[19:15]} : rs1_val_i;

  always_comb begin
    old_val = '0;
    case (addr)
      fpu_ss_pkg::csr_fflags: old_val[4:0] = fflags_q;
      fpu_ss_pkg::csr_frm:    old_val[2:0] = frm_q;
      // fcsr is frm stacked on fflags
      fpu_ss_pkg::csr_fcsr:   old_val[7:0] = {frm_q, fflags_q};
      default: ;
    endcase
    case (funct3[1:0])
      2'b01:   new_val = operand;
      2'b10:   new_val = old_val | operand;
      2'b11:   new_val = old_val & ~operand;
      default: new_val = old_val;
    endcase
  end

  assign rdata_o = old_val;

  always_comb begin
    fflags_d = fflags_q;
    frm_d    = frm_q;
    if (csr_en_i) begin
      case (addr)
        fpu_ss_pkg::csr_fflags: fflags_d = new_val[4:0];
        fpu_ss_pkg::csr_frm:    frm_d    = new_val[2:0];
        fpu_ss_pkg::csr_fcsr: begin
          fflags_d = new_val[4:0];
          frm_d    = new_val[7:5];
        end
        default: ;
      endcase
    end
    // sticky flags from the retiring result
    if (flags_set_en_i) begin
      fflags_d = fflags_d | flags_set_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fflags_q <= '0;
      frm_q    <= '0;
    end else begin
      fflags_q <= fflags_d;
      frm_q    <= frm_d;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_regfile.sv ====
/*
 * floating-point register file
 * 32 x 32-bit, two combinational read ports and one write port
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_regfile (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [fpu_ss_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [fpu_ss_pkg::reg_addr_w-1:0] raddr_b_i,
  output logic [fpu_ss_pkg::flen-1:0]       rdata_a_o,
  output logic [fpu_ss_pkg::flen-1:0]       rdata_b_o,
  input  logic [fpu_ss_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [fpu_ss_pkg::flen-1:0]       wdata_i,
  input  logic                              we_i
);

  logic [fpu_ss_pkg::flen-1:0] regs_q [2**fpu_ss_pkg::reg_addr_w];

  // f0 is an ordinary register, unlike x0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2**fpu_ss_pkg::reg_addr_w; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_exec.sv ====
/*
 * execution stage
 * one registered stage for sign injection, min/max, compares, fclass,
 * moves and CSR read data; fp results retire into the register file,
 * integer results wait for the core's response handshake
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_exec (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     issue_valid_i,
  input  fpu_ss_pkg::issue_t       issue_i,
  output logic                     exec_ready_o,
  input  logic                     c_p_ready_i,
  output logic                     out_valid_o,
  output fpu_ss_pkg::offload_rsp_t rsp_o,
  output logic                     rd_is_fp_o,
  output logic                     nv_o,
  output logic                     fpr_we_o
);

  function automatic logic is_nan(input logic [fpu_ss_pkg::flen-1:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  function automatic logic is_snan(input logic [fpu_ss_pkg::flen-1:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // total order on non-NaN values, -0 sorts below +0
  function automatic logic ord_lt(input logic [fpu_ss_pkg::flen-1:0] a,
                                  input logic [fpu_ss_pkg::flen-1:0] b);
    if (a[31] != b[31]) begin
      return a[31];
    end
    return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
  endfunction

  function automatic logic [9:0] fclass(input logic [fpu_ss_pkg::flen-1:0] x);
    logic       exp_max;
    logic       exp_zero;
    logic       man_zero;
    logic [9:0] cls;
    exp_max  = (x[30:23] == 8'hff);
    exp_zero = (x[30:23] == 8'h00);
    man_zero = (x[22:0] == '0);
    cls      = '0;
    if (exp_max && !man_zero) begin
      cls[x[22] ? 9 : 8] = 1'b1;
    end else if (exp_max) begin
      cls[x[31] ? 0 : 7] = 1'b1;
    end else if (exp_zero && man_zero) begin
      cls[x[31] ? 3 : 4] = 1'b1;
    end else if (exp_zero) begin
      cls[x[31] ? 2 : 5] = 1'b1;
    end else begin
      cls[x[31] ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

  logic [fpu_ss_pkg::flen-1:0] a;
  logic [fpu_ss_pkg::flen-1:0] b;
  logic                        a_nan;
  logic                        b_nan;
  logic                        any_snan;
  logic                        both_zero;
  logic                        feq;
  logic                        flt;
  logic [fpu_ss_pkg::xlen-1:0] res;
  logic                        nv;
  logic                        err;
  logic                        retire;
  logic                        load;

  assign a         = issue_i.operand_a;
  assign b         = issue_i.operand_b;
  assign a_nan     = is_nan(a);
  assign b_nan     = is_nan(b);
  assign any_snan  = is_snan(a) || is_snan(b);
  assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
  // IEEE compares treat the two zeros as equal
  assign feq       = !a_nan && !b_nan && ((a == b) || both_zero);
  assign flt       = !a_nan && !b_nan && !both_zero && ord_lt(a, b);

  always_comb begin
    res = '0;
    nv  = 1'b0;
    err = 1'b0;
    case (issue_i.dec.op)
      fpu_ss_pkg::op_sgnj:  res = {b[31], a[30:0]};
      fpu_ss_pkg::op_sgnjn: res = {~b[31], a[30:0]};
      fpu_ss_pkg::op_sgnjx: res = {a[31] ^ b[31], a[30:0]};
      fpu_ss_pkg::op_min, fpu_ss_pkg::op_max: begin
        nv = any_snan;
        if (a_nan && b_nan) begin
          res = fpu_ss_pkg::qnan_canon;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else begin
          res = (ord_lt(a, b) == (issue_i.dec.op == fpu_ss_pkg::op_min)) ? a : b;
        end
      end
      fpu_ss_pkg::op_eq: begin
        res[0] = feq;
        nv     = any_snan;
      end
      // signaling compares flag any NaN operand
      fpu_ss_pkg::op_lt: begin
        res[0] = flt;
        nv     = a_nan || b_nan;
      end
      fpu_ss_pkg::op_le: begin
        res[0] = flt || feq;
        nv     = a_nan || b_nan;
      end
      fpu_ss_pkg::op_class: res[9:0] = fclass(a);
      // operand_a is already the fp or integer source
      fpu_ss_pkg::op_mv_xw, fpu_ss_pkg::op_mv_wx: res = a;
      fpu_ss_pkg::op_csr: res = issue_i.csr_rdata;
      default: err = 1'b1;
    endcase
  end

  // fp results retire unconditionally, integer ones need the core
  assign retire       = out_valid_o && (rd_is_fp_o || c_p_ready_i);
  assign exec_ready_o = !out_valid_o || retire;
  assign load         = issue_valid_i && exec_ready_o;
  assign fpr_we_o     = out_valid_o && rd_is_fp_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (retire) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rsp_o.data    <= res;
      rsp_o.rd      <= issue_i.dec.rd;
      rsp_o.hart_id <= issue_i.hart_id;
      rsp_o.error   <= err;
      rd_is_fp_o    <= issue_i.dec.rd_is_fp;
      nv_o          <= nv;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_controller.sv ====
/*
 * issue controller
 * releases the buffer head into the execution stage unless a register
 * hazard or CSR ordering rule holds it back
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_controller (
  input  logic                              pop_valid_i,
  input  fpu_ss_pkg::decoded_t              dec_i,
  input  logic                              exec_busy_i,
  input  logic [fpu_ss_pkg::reg_addr_w-1:0] exec_rd_i,
  input  logic                              exec_rd_is_fp_i,
  input  logic                              exec_ready_i,
  output logic                              issue_o,
  output logic                              csr_en_o
);

  logic pending_fp;
  logic raw_rs1;
  logic raw_rs2;
  logic hazard_stall;
  logic csr_stall;

  // the pending fp result lands in the regfile at the next edge
  assign pending_fp = exec_busy_i && exec_rd_is_fp_i;
  assign raw_rs1    = dec_i.uses_fpr_rs1 && (dec_i.rs1 == exec_rd_i);
  assign raw_rs2    = dec_i.uses_fpr_rs2 && (dec_i.rs2 == exec_rd_i);

  assign hazard_stall = pending_fp && (raw_rs1 || raw_rs2);

  // wait for earlier flags to accumulate before a CSR reads fflags
  assign csr_stall = dec_i.is_csr && exec_busy_i;

  assign issue_o  = pop_valid_i && !hazard_stall && !csr_stall && exec_ready_i;
  assign csr_en_o = issue_o && dec_i.is_csr;

endmodule

`default_nettype wire

// ==== rtl/fpu_ss_top.sv ====
/*
 * fpu subsystem top
 * offload request channel into the buffer, decode and issue from the
 * head, one execution stage, fp register file and response channel
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     c_q_valid_i,
  output logic                     c_q_ready_o,
  input  fpu_ss_pkg::offload_req_t c_q_req_i,
  output logic                     c_p_valid_o,
  input  logic                     c_p_ready_i,
  output fpu_ss_pkg::offload_rsp_t c_p_rsp_o
);

  fpu_ss_pkg::offload_req_t    head;
  fpu_ss_pkg::decoded_t        dec;
  fpu_ss_pkg::issue_t          issue;
  fpu_ss_pkg::offload_rsp_t    exec_rsp;
  logic                        pop_valid;
  logic                        issue_en;
  logic                        csr_en;
  logic                        exec_ready;
  logic                        exec_valid;
  logic                        exec_rd_is_fp;
  logic                        exec_nv;
  logic                        fpr_we;
  logic [fpu_ss_pkg::flen-1:0] fpr_a;
  logic [fpu_ss_pkg::flen-1:0] fpr_b;
  logic [fpu_ss_pkg::xlen-1:0] csr_rdata;
  logic [4:0]                  nv_flags;

  fpu_ss_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (c_q_valid_i),
    .push_ready_o (c_q_ready_o),
    .push_data_i  (c_q_req_i),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (issue_en),
    .pop_data_o   (head)
  );

  fpu_ss_decoder u_decoder (
    .instr_i (head.instr),
    .dec_o   (dec)
  );

  fpu_ss_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (fpr_a),
    .rdata_b_o (fpr_b),
    .waddr_i   (exec_rsp.rd),
    .wdata_i   (exec_rsp.data),
    .we_i      (fpr_we)
  );

  // only nv can be raised by the kept operations
  assign nv_flags = 5'(exec_nv) << fpu_ss_pkg::flag_nv;

  // valid and ready together mark the retiring cycle
  fpu_ss_csr u_csr (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_i        (head.instr),
    .rs1_val_i      (head.rs1),
    .csr_en_i       (csr_en),
    .flags_set_i    (nv_flags),
    .flags_set_en_i (exec_valid && exec_ready),
    .rdata_o        (csr_rdata)
  );

  fpu_ss_controller u_controller (
    .pop_valid_i     (pop_valid),
    .dec_i           (dec),
    .exec_busy_i     (exec_valid),
    .exec_rd_i       (exec_rsp.rd),
    .exec_rd_is_fp_i (exec_rd_is_fp),
    .exec_ready_i    (exec_ready),
    .issue_o         (issue_en),
    .csr_en_o        (csr_en)
  );

  // fmv.w.x takes the integer rs1, everything else reads the fp register
  assign issue.dec       = dec;
  assign issue.operand_a = (dec.op == fpu_ss_pkg::op_mv_wx) ? head.rs1 : fpr_a;
  assign issue.operand_b = fpr_b;
  assign issue.csr_rdata = csr_rdata;
  assign issue.hart_id   = head.hart_id;

  fpu_ss_exec u_exec (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_en),
    .issue_i       (issue),
    .exec_ready_o  (exec_ready),
    .c_p_ready_i   (c_p_ready_i),
    .out_valid_o   (exec_valid),
    .rsp_o         (exec_rsp),
    .rd_is_fp_o    (exec_rd_is_fp),
    .nv_o          (exec_nv),
    .fpr_we_o      (fpr_we)
  );

  assign c_p_valid_o = exec_valid && !exec_rd_is_fp;
  assign c_p_rsp_o   = exec_rsp;

endmodule

`default_nettype wire

// ==== bench/fpu_ss_tb_vectors.svh ====
/*
 * fpu subsystem testbench vectors
 * instruction encoders and the ordered table of offloaded instructions,
 * each with the response the core should see for it
 */
`ifndef FPU_SS_TB_VECTORS_SVH
`define FPU_SS_TB_VECTORS_SVH

typedef struct packed {
  logic [31:0] instr;
  logic [31:0] rs1;
  logic        has_rsp;
  logic [31:0] data;
  logic        err;
} vec_t;

vec_t vecs[$];

// R-type word in the OP-FP major opcode
function automatic logic [31:0] enc_fp(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
  return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b1010011};
endfunction

// Zicsr word, src is either the rs1 index or the 5-bit uimm
function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [11:0] addr,
                                        input int src, input int rd);
  return {addr, 5'(src), f3, 5'(rd), 7'b1110011};
endfunction

task automatic add_entry(input logic [31:0] instr, input logic [31:0] rs1,
                         input int has_rsp, input logic [31:0] data, input int err);
  vec_t v;
  v.instr   = instr;
  v.rs1     = rs1;
  v.has_rsp = (has_rsp != 0);
  v.data    = data;
  v.err     = (err != 0);
  vecs.push_back(v);
endtask

// fmv.w.x fd, with the integer value riding in the request
task automatic load_fpr(input int fd, input logic [31:0] val);
  add_entry(enc_fp(7'b1111000, 3'b000, fd, 1, 0), val, 0, '0, 0);
endtask

// fmv.x.w xd, fs returns the raw bit pattern
task automatic read_fpr(input int xd, input int fs, input logic [31:0] exp);
  add_entry(enc_fp(7'b1110000, 3'b000, xd, fs, 0), '0, 1, exp, 0);
endtask

task automatic fp_to_fp(input logic [6:0] f7, input logic [2:0] f3,
                        input int fd, input int fs1, input int fs2);
  add_entry(enc_fp(f7, f3, fd, fs1, fs2), '0, 0, '0, 0);
endtask

// compares land in x11
task automatic fp_to_int(input logic [2:0] f3, input int fs1, input int fs2,
                         input logic [31:0] exp);
  add_entry(enc_fp(7'b1010000, f3, 11, fs1, fs2), '0, 1, exp, 0);
endtask

task automatic classify(input int fs, input logic [31:0] exp);
  add_entry(enc_fp(7'b1110000, 3'b001, 12, fs, 0), '0, 1, exp, 0);
endtask

// CSR reads land in x10, exp is the old value
task automatic csr_access(input logic [2:0] f3, input logic [11:0] addr, input int src,
                          input logic [31:0] rs1_val, input logic [31:0] exp);
  add_entry(enc_csr(f3, addr, src, 10), rs1_val, 1, exp, 0);
endtask

task automatic build_table();
  // moves, each read depends on the write just before it
  load_fpr(1, 32'h3fc00000);
  read_fpr(5, 1, 32'h3fc00000);
  load_fpr(2, 32'hc0200000);
  read_fpr(6, 2, 32'hc0200000);
  // sign injection, 1.5 and -2.5
  fp_to_fp(7'b0010000, 3'b000, 3, 1, 2);
  read_fpr(7, 3, 32'hbfc00000);
  fp_to_fp(7'b0010000, 3'b001, 4, 1, 2);
  read_fpr(8, 4, 32'h3fc00000);
  fp_to_fp(7'b0010000, 3'b010, 5, 2, 2);
  read_fpr(9, 5, 32'h40200000);
  // min and max on ordinary values
  fp_to_fp(7'b0010100, 3'b000, 6, 1, 2);
  read_fpr(13, 6, 32'hc0200000);
  fp_to_fp(7'b0010100, 3'b001, 7, 1, 2);
  read_fpr(14, 7, 32'h3fc00000);
  // signed zeros, -0 is the smaller one
  load_fpr(8, 32'h00000000);
  load_fpr(9, 32'h80000000);
  fp_to_fp(7'b0010100, 3'b000, 10, 8, 9);
  read_fpr(15, 10, 32'h80000000);
  fp_to_fp(7'b0010100, 3'b001, 11, 9, 8);
  read_fpr(16, 11, 32'h00000000);
  // one quiet NaN gives the other operand
  load_fpr(12, 32'h7fc00001);
  fp_to_fp(7'b0010100, 3'b000, 13, 12, 1);
  read_fpr(17, 13, 32'h3fc00000);
  fp_to_fp(7'b0010100, 3'b001, 14, 2, 12);
  read_fpr(18, 14, 32'hc0200000);
  // two NaNs give the canonical NaN, the signaling one raises nv
  load_fpr(15, 32'h7f800001);
  fp_to_fp(7'b0010100, 3'b000, 16, 12, 15);
  read_fpr(19, 16, 32'h7fc00000);
  csr_access(3'b111, 12'h001, 5'h1f, '0, 32'h10);
  // compares, quiet NaN feq leaves the flags alone
  fp_to_int(3'b010, 1, 1, 32'd1);
  fp_to_int(3'b010, 1, 2, 32'd0);
  fp_to_int(3'b010, 8, 9, 32'd1);
  fp_to_int(3'b001, 2, 1, 32'd1);
  fp_to_int(3'b001, 1, 2, 32'd0);
  fp_to_int(3'b000, 1, 1, 32'd1);
  fp_to_int(3'b000, 1, 2, 32'd0);
  fp_to_int(3'b010, 12, 1, 32'd0);
  csr_access(3'b010, 12'h001, 0, '0, 32'h00);
  // flt with a NaN raises nv, csrrc clears it again
  fp_to_int(3'b001, 12, 1, 32'd0);
  csr_access(3'b010, 12'h001, 0, '0, 32'h10);
  csr_access(3'b011, 12'h001, 2, 32'h10, 32'h10);
  csr_access(3'b010, 12'h001, 0, '0, 32'h00);
  // fclass across all ten classes
  load_fpr(17, 32'hff800000);
  load_fpr(18, 32'h7f800000);
  load_fpr(19, 32'h00000001);
  load_fpr(20, 32'h80000001);
  classify(17, 32'h001);
  classify(2, 32'h002);
  classify(20, 32'h004);
  classify(9, 32'h008);
  classify(8, 32'h010);
  classify(19, 32'h020);
  classify(1, 32'h040);
  classify(18, 32'h080);
  classify(15, 32'h100);
  classify(12, 32'h200);
  // frm and fcsr, register and immediate forms
  csr_access(3'b001, 12'h002, 3, 32'd3, 32'h00);
  fp_to_int(3'b001, 15, 1, 32'd0);
  csr_access(3'b010, 12'h003, 0, '0, 32'h70);
  csr_access(3'b101, 12'h002, 5, '0, 32'h03);
  csr_access(3'b110, 12'h001, 1, '0, 32'h10);
  csr_access(3'b111, 12'h003, 5'h1f, '0, 32'hb1);
  csr_access(3'b010, 12'h003, 0, '0, 32'ha0);
  // addi and a double-precision fsgnj are both unknown here
  add_entry(32'h00000013, '0, 1, '0, 1);
  add_entry(enc_fp(7'b0010001, 3'b000, 3, 1, 2), '0, 1, '0, 1);
  // closing burst of reads
  read_fpr(20, 6, 32'hc0200000);
  read_fpr(21, 10, 32'h80000000);
  read_fpr(22, 16, 32'h7fc00000);
  read_fpr(23, 3, 32'hbfc00000);
endtask

`endif

// ==== bench/fpu_ss_tb.sv ====
/*
 * fpu subsystem testbench
 * drives the offload request channel from the vector table and checks
 * every response in order while the core's ready toggles at random
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_ss_tb;

  `include "fpu_ss_tb_vectors.svh"

  // cycles any single wait may take
  localparam int timeout_cycles = 300;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     c_q_valid_i;
  logic                     c_q_ready_o;
  fpu_ss_pkg::offload_req_t c_q_req_i;
  logic                     c_p_valid_o;
  logic                     c_p_ready_i;
  fpu_ss_pkg::offload_rsp_t c_p_rsp_o;

  int          n_rsp;
  int          exp_idx[$];

  fpu_ss_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .c_q_valid_i (c_q_valid_i),
    .c_q_ready_o (c_q_ready_o),
    .c_q_req_i   (c_q_req_i),
    .c_p_valid_o (c_p_valid_o),
    .c_p_ready_i (c_p_ready_i),
    .c_p_rsp_o   (c_p_rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1, "stopped on a timeout");
  endtask

  // one request per entry, held until the buffer takes it
  task automatic drive_all();
    int waited;
    for (int i = 0; i < vecs.size(); i++) begin
      c_q_valid_i       = 1'b1;
      c_q_req_i.instr   = vecs[i].instr;
      c_q_req_i.rs1     = vecs[i].rs1;
      c_q_req_i.hart_id = 32'(i + 100);
      waited = 0;
      // ready only follows the buffer count, so it is settled here
      while (!c_q_ready_o) begin
        @(negedge clk_i);
        waited++;
        if (waited > timeout_cycles) begin
          fail_run("the request buffer stopped accepting requests");
        end
      end
      // the transfer happens at the coming rising edge
      @(negedge clk_i);
    end
    c_q_valid_i = 1'b0;
    c_q_req_i   = '0;
  endtask

  // compare each handshake against the next entry that expects a response
  task automatic watch_responses();
    int idle;
    int idx;
    idle = 0;
    while (n_rsp < exp_idx.size()) begin
      @(negedge clk_i);
      c_p_ready_i = (($urandom % 4) != 0);
      if (c_p_valid_o && c_p_ready_i) begin
        idx = exp_idx[n_rsp];
        check_value($sformatf("entry %0d data", idx), c_p_rsp_o.data, vecs[idx].data);
        check_value($sformatf("entry %0d error", idx), 32'(c_p_rsp_o.error),
                    32'(vecs[idx].err));
        // rd is echoed straight from the instruction word
        check_value($sformatf("entry %0d rd", idx), 32'(c_p_rsp_o.rd),
                    32'(vecs[idx].instr[11:7]));
        check_value($sformatf("entry %0d hart id", idx), c_p_rsp_o.hart_id,
                    32'(idx + 100));
        n_rsp++;
        idle = 0;
      end else begin
        idle++;
        if (idle > timeout_cycles) begin
          fail_run("an expected response never arrived");
        end
      end
    end
  endtask

  initial begin
    void'($urandom(32'he0b64064));
    n_rsp       = 0;
    rst_ni      = 1'b0;
    c_q_valid_i = 1'b0;
    c_q_req_i   = '0;
    c_p_ready_i = 1'b0;

    build_table();
    for (int i = 0; i < vecs.size(); i++) begin
      if (vecs[i].has_rsp) begin
        exp_idx.push_back(i);
      end
    end

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("request ready after reset", 32'(c_q_ready_o), 32'd1);
    check_value("response valid after reset", 32'(c_p_valid_o), 32'd0);

    fork
      drive_all();
      watch_responses();
    join

    // the last handshake empties the stage, nothing may follow it
    @(negedge clk_i);
    check_value("response valid after the last entry", 32'(c_p_valid_o), 32'd0);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+bench
rtl/fpu_ss_pkg.sv
rtl/fpu_ss_buffer.sv
rtl/fpu_ss_decoder.sv
rtl/fpu_ss_csr.sv
rtl/fpu_ss_regfile.sv
rtl/fpu_ss_exec.sv
rtl/fpu_ss_controller.sv
rtl/fpu_ss_top.sv
bench/fpu_ss_tb.sv

// ==== Makefile ====
TOP := fpu_ss_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
